// ==== leaf_pkg.sv ====
package leaf_pkg;

    // ==========================================================================
    // packet layout, valid bit on top and payload at the bottom
    // ==========================================================================
    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int addr_bits    = 7;

    typedef logic [packet_bits-1:0]  packet_t;
    typedef logic [payload_bits-1:0] payload_t;
    typedef logic [leaf_bits-1:0]    leaf_t;
    typedef logic [port_bits-1:0]    port_t;
    typedef logic [addr_bits-1:0]    addr_t;

    localparam int pkt_vld_bit  = packet_bits - 1;             // 48
    localparam int pkt_leaf_lsb = pkt_vld_bit - leaf_bits;     // 47:43
    localparam int pkt_port_lsb = pkt_leaf_lsb - port_bits;    // 42:39
    localparam int pkt_addr_lsb = pkt_port_lsb - addr_bits;    // 38:32

    // ==========================================================================
    // kernel ports
    // ==========================================================================
    localparam port_t cfg_port     = 4'd0;     // destination table writes
    localparam port_t in_port_base = 4'd2;     // input 1, input 2 is next
    localparam int    num_in       = 2;
    localparam int    num_out      = 5;

    localparam int out_sel_bits = 3;
    typedef logic [out_sel_bits-1:0] out_sel_t;

    // config payload: [2:0] output, [7:3] leaf, [11:8] port
    localparam int cfg_leaf_lsb = out_sel_bits;
    localparam int cfg_port_lsb = cfg_leaf_lsb + leaf_bits;

endpackage

// ==== leaf_fifo.sv ====
`timescale 1ns/1ps

module leaf_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty,
    output logic             full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;   // depth need not be a power of 2
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CW'(DEPTH));
    assign do_pop   = pop && !empty;
    assign do_push  = push && (!full || do_pop);        // full slot frees on same-cycle pop
    assign pop_data = mem[rd_ptr];                      // first word fall-through

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== leaf_decode.sv ====
`timescale 1ns/1ps

module leaf_decode #(
    parameter leaf_pkg::leaf_t LEAF_ADDR = 5'd1,
    parameter int              IN_DEPTH  = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  leaf_pkg::packet_t             din,
    output leaf_pkg::payload_t            in_data [leaf_pkg::num_in],
    output logic [leaf_pkg::num_in-1:0]   in_vld,
    input  logic [leaf_pkg::num_in-1:0]   in_ack,
    output logic [leaf_pkg::num_in-1:0]   credit_out,
    output leaf_pkg::leaf_t               dest_leaf [leaf_pkg::num_out],
    output leaf_pkg::port_t               dest_port [leaf_pkg::num_out]
);

    leaf_pkg::leaf_t                 pkt_leaf;
    leaf_pkg::port_t                 pkt_port;
    leaf_pkg::payload_t              pkt_payload;
    logic                            pkt_here;
    leaf_pkg::out_sel_t              cfg_sel;
    logic                            cfg_wr;
    logic [leaf_pkg::num_in-1:0]     fifo_push;
    logic [leaf_pkg::num_in-1:0]     fifo_empty;
    logic [leaf_pkg::num_in-1:0]     fifo_full;

    // ==========================================================================
    // field split and address match
    // ==========================================================================
    assign pkt_leaf    = din[leaf_pkg::pkt_leaf_lsb +: leaf_pkg::leaf_bits];
    assign pkt_port    = din[leaf_pkg::pkt_port_lsb +: leaf_pkg::port_bits];
    assign pkt_payload = din[leaf_pkg::pkt_addr_lsb-1:0];
    assign pkt_here    = din[leaf_pkg::pkt_vld_bit] && (pkt_leaf == LEAF_ADDR);

    assign cfg_sel = pkt_payload[leaf_pkg::out_sel_bits-1:0];
    assign cfg_wr  = pkt_here && (pkt_port == leaf_pkg::cfg_port)
                  && (cfg_sel < leaf_pkg::out_sel_t'(leaf_pkg::num_out));  // 5..7 ignored

    // ==========================================================================
    // destination table
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < leaf_pkg::num_out; j++) begin
                dest_leaf[j] <= '0;
                dest_port[j] <= '0;
            end
        end else if (cfg_wr) begin
            dest_leaf[cfg_sel] <= pkt_payload[leaf_pkg::cfg_leaf_lsb +: leaf_pkg::leaf_bits];
            dest_port[cfg_sel] <= pkt_payload[leaf_pkg::cfg_port_lsb +: leaf_pkg::port_bits];
        end
    end

    // ==========================================================================
    // input buffers toward the kernel
    // ==========================================================================
    for (genvar i = 0; i < leaf_pkg::num_in; i++) begin : g_in
        // sender credits keep this from filling, full check is only a guard
        assign fifo_push[i] = pkt_here && !fifo_full[i]
                           && (pkt_port == leaf_pkg::port_t'(leaf_pkg::in_port_base + i));

        leaf_fifo #(
            .WIDTH (leaf_pkg::payload_bits),
            .DEPTH (IN_DEPTH)
        ) in_fifo_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (fifo_push[i]),
            .push_data (pkt_payload),
            .pop       (credit_out[i]),
            .pop_data  (in_data[i]),
            .empty     (fifo_empty[i]),
            .full      (fifo_full[i])
        );
    end

    assign in_vld     = ~fifo_empty;
    assign credit_out = in_vld & in_ack;    // one credit per consumed word

endmodule

// ==== leaf_kernel.sv ====
`timescale 1ns/1ps

module leaf_kernel (
    input  logic                          clk,
    input  logic                          rst_n,
    input  leaf_pkg::payload_t            in_data [leaf_pkg::num_in],
    input  logic [leaf_pkg::num_in-1:0]   in_vld,
    output logic [leaf_pkg::num_in-1:0]   in_ack,
    output leaf_pkg::payload_t            out_data,
    output logic [leaf_pkg::num_out-1:0]  out_vld,
    input  logic [leaf_pkg::num_out-1:0]  out_ack
);

    typedef enum logic {
        st_empty,
        st_full
    } state_t;

    state_t                          state;
    leaf_pkg::payload_t              sum;
    leaf_pkg::out_sel_t              sel;
    leaf_pkg::out_sel_t              sel_q;
    logic [leaf_pkg::num_out-1:0]    onehot;
    logic                            drain;
    logic                            free;
    logic                            take;

    // ==========================================================================
    // execute, add and steer
    // ==========================================================================
    assign sum = in_data[0] + in_data[1];                      // 32-bit wrap
    assign sel = leaf_pkg::out_sel_t'(sum % leaf_pkg::payload_t'(leaf_pkg::num_out));

    assign drain  = |(out_vld & out_ack);
    assign free   = (state == st_empty) || drain;              // output reg free or draining
    assign take   = (&in_vld) && free;
    assign in_ack = {leaf_pkg::num_in{take}};

    assign onehot  = {{(leaf_pkg::num_out-1){1'b0}}, 1'b1} << sel_q;
    assign out_vld = (state == st_full) ? onehot : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_empty;
        end else begin
            case (state)
                st_empty: begin
                    if (take) state <= st_full;
                end
                st_full: begin
                    if (drain && !take) state <= st_empty;     // back-to-back keeps full
                end
                default: state <= st_empty;
            endcase
        end
    end

    // result register, held until acked
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= sum;
            sel_q    <= sel;
        end
    end

endmodule

// ==== leaf_result.sv ====
`timescale 1ns/1ps

module leaf_result #(
    parameter int OUT_DEPTH = 4,
    parameter int CREDITS   = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  leaf_pkg::payload_t            out_data,
    input  logic [leaf_pkg::num_out-1:0]  out_vld,
    output logic [leaf_pkg::num_out-1:0]  out_ack,
    input  leaf_pkg::leaf_t               dest_leaf [leaf_pkg::num_out],
    input  leaf_pkg::port_t               dest_port [leaf_pkg::num_out],
    input  logic                          credit_in,
    output leaf_pkg::packet_t             dout
);

    localparam int CW = $clog2(CREDITS + 1);

    leaf_pkg::payload_t              fifo_data [leaf_pkg::num_out];
    logic [leaf_pkg::num_out-1:0]    fifo_push;
    logic [leaf_pkg::num_out-1:0]    fifo_pop;
    logic [leaf_pkg::num_out-1:0]    fifo_empty;
    logic [leaf_pkg::num_out-1:0]    fifo_full;
    leaf_pkg::addr_t                 seq [leaf_pkg::num_out];
    leaf_pkg::out_sel_t              rr_ptr;
    leaf_pkg::out_sel_t              pick;
    logic                            pick_ok;
    logic                            send;
    logic [CW-1:0]                   credit_cnt;

    // ==========================================================================
    // per-port output buffers
    // ==========================================================================
    assign out_ack   = ~fifo_full;
    assign fifo_push = out_vld & out_ack;

    for (genvar p = 0; p < leaf_pkg::num_out; p++) begin : g_out
        assign fifo_pop[p] = send && (pick == leaf_pkg::out_sel_t'(p));

        leaf_fifo #(
            .WIDTH (leaf_pkg::payload_bits),
            .DEPTH (OUT_DEPTH)
        ) out_fifo_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (fifo_push[p]),
            .push_data (out_data),
            .pop       (fifo_pop[p]),
            .pop_data  (fifo_data[p]),
            .empty     (fifo_empty[p]),
            .full      (fifo_full[p])
        );
    end

    // ==========================================================================
    // round-robin pick, first non-empty from rr_ptr
    // ==========================================================================
    always_comb begin : rr_pick
        int j;
        pick    = rr_ptr;
        pick_ok = 1'b0;
        for (int k = leaf_pkg::num_out - 1; k >= 0; k--) begin   // k = 0 wins
            j = int'(rr_ptr) + k;
            if (j >= leaf_pkg::num_out) j = j - leaf_pkg::num_out;
            if (!fifo_empty[j]) begin
                pick    = leaf_pkg::out_sel_t'(j);
                pick_ok = 1'b1;
            end
        end
    end

    assign send = pick_ok && (credit_cnt != '0);

    // ==========================================================================
    // packetizer and credit counter
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout       <= '0;
            rr_ptr     <= '0;
            credit_cnt <= CW'(CREDITS);
            for (int q = 0; q < leaf_pkg::num_out; q++) begin
                seq[q] <= '0;
            end
        end else begin
            dout <= '0;                                         // idle cycles send zero
            if (send) begin
                dout <= {1'b1, dest_leaf[pick], dest_port[pick], seq[pick], fifo_data[pick]};
                seq[pick] <= seq[pick] + 1'b1;                  // wraps at 128
                rr_ptr    <= (pick == leaf_pkg::out_sel_t'(leaf_pkg::num_out - 1)) ?
                             '0 : pick + 1'b1;
            end
            case ({send, credit_in})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;              // both or neither
            endcase
        end
    end

endmodule

// ==== leaf_i2o5.sv ====
`timescale 1ns/1ps

module leaf_i2o5 #(
    parameter leaf_pkg::leaf_t LEAF_ADDR = 5'd1,
    parameter int              IN_DEPTH  = 8,
    parameter int              OUT_DEPTH = 4,
    parameter int              CREDITS   = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  leaf_pkg::packet_t             din,
    output leaf_pkg::packet_t             dout,
    input  logic                          credit_in,
    output logic [leaf_pkg::num_in-1:0]   credit_out
);

    leaf_pkg::payload_t              in_data [leaf_pkg::num_in];
    logic [leaf_pkg::num_in-1:0]     in_vld;
    logic [leaf_pkg::num_in-1:0]     in_ack;
    leaf_pkg::payload_t              out_data;
    logic [leaf_pkg::num_out-1:0]    out_vld;
    logic [leaf_pkg::num_out-1:0]    out_ack;
    leaf_pkg::leaf_t                 dest_leaf [leaf_pkg::num_out];
    leaf_pkg::port_t                 dest_port [leaf_pkg::num_out];

    leaf_decode #(
        .LEAF_ADDR (LEAF_ADDR),
        .IN_DEPTH  (IN_DEPTH)
    ) decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (din),
        .in_data    (in_data),
        .in_vld     (in_vld),
        .in_ack     (in_ack),
        .credit_out (credit_out),
        .dest_leaf  (dest_leaf),
        .dest_port  (dest_port)
    );

    leaf_kernel kernel_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (in_data),
        .in_vld   (in_vld),
        .in_ack   (in_ack),
        .out_data (out_data),
        .out_vld  (out_vld),
        .out_ack  (out_ack)
    );

    leaf_result #(
        .OUT_DEPTH (OUT_DEPTH),
        .CREDITS   (CREDITS)
    ) result_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_data  (out_data),
        .out_vld   (out_vld),
        .out_ack   (out_ack),
        .dest_leaf (dest_leaf),
        .dest_port (dest_port),
        .credit_in (credit_in),
        .dout      (dout)
    );

endmodule

// ==== tb_leaf_i2o5.sv ====
`timescale 1ns/1ps

module tb_leaf_i2o5;

    localparam leaf_pkg::leaf_t leaf_addr = 5'd9;
    localparam int in_depth    = 8;
    localparam int out_depth   = 4;
    localparam int credits     = 4;
    localparam int n_pairs     = 120;
    localparam int n_drop      = 24;
    localparam int hold_at     = 40;      // input 1 words sent before credit_in stops
    localparam int hold_len    = 120;
    localparam int total_words = 2 * n_pairs + leaf_pkg::num_out + n_drop;

    logic                          clk;
    logic                          rst_n;
    leaf_pkg::packet_t             din;
    leaf_pkg::packet_t             dout;
    logic                          credit_in;
    logic [leaf_pkg::num_in-1:0]   credit_out;

    logic [31:0]           lfsr;
    int                    errors;
    int                    checks;
    int                    cred [leaf_pkg::num_in];         // sender credit model
    int                    pend [leaf_pkg::num_in];         // seen, usable next cycle
    int                    co_total [leaf_pkg::num_in];
    int                    sent [leaf_pkg::num_in];
    leaf_pkg::payload_t    a_words [n_pairs];
    leaf_pkg::payload_t    b_words [n_pairs];
    int                    npaired;
    leaf_pkg::leaf_t       tbl_leaf [leaf_pkg::num_out];
    leaf_pkg::port_t       tbl_port [leaf_pkg::num_out];
    leaf_pkg::addr_t       exp_seq [leaf_pkg::num_out];
    leaf_pkg::packet_t     exp_mem [leaf_pkg::num_out][n_pairs];
    int                    exp_head [leaf_pkg::num_out];
    int                    exp_tail [leaf_pkg::num_out];
    int                    rx_count;
    int                    owed;                            // packets not yet credited back
    int                    credit_pulses;
    bit                    hold;
    bit                    hold_done;
    int                    hold_cycles;

    leaf_i2o5 #(
        .LEAF_ADDR (leaf_addr),
        .IN_DEPTH  (in_depth),
        .OUT_DEPTH (out_depth),
        .CREDITS   (credits)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .din        (din),
        .dout       (dout),
        .credit_in  (credit_in),
        .credit_out (credit_out)
    );

    always #2 clk = ~clk;

    // ==========================================================================
    // random numbers and packet builders
    // ==========================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic leaf_pkg::packet_t make_packet(input leaf_pkg::leaf_t leaf,
                                                      input leaf_pkg::port_t port,
                                                      input leaf_pkg::payload_t data);
        return {1'b1, leaf, port, leaf_pkg::addr_t'(0), data};
    endfunction

    // wrong leaf, unused port or config with output index 5..7
    function automatic leaf_pkg::packet_t drop_packet();
        int                 kind;
        leaf_pkg::payload_t junk;
        leaf_pkg::packet_t  pkt;
        kind = int'(rand_bits(2));
        junk = rand_bits(32);
        if (kind == 0) begin
            pkt = make_packet(leaf_addr ^ leaf_pkg::leaf_t'(1 + int'(rand_bits(4))),
                              leaf_pkg::port_t'(int'(leaf_pkg::in_port_base) + int'(rand_bits(1))),
                              junk);
        end else if (kind == 1) begin
            pkt = make_packet(leaf_addr, leaf_pkg::port_t'(4 + int'(rand_bits(3))), junk);
        end else begin
            pkt = make_packet(leaf_addr, leaf_pkg::cfg_port,
                              {junk[31:3], leaf_pkg::out_sel_t'(5 + int'(rand_bits(2)) % 3)});
        end
        return pkt;
    endfunction

    // ==========================================================================
    // reference model and checks
    // ==========================================================================
    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("Fail %s: expected %0h, actual %0h", test, expected, actual);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic pair_words();
        leaf_pkg::payload_t s;
        int                 p;
        while (npaired < sent[0] && npaired < sent[1]) begin
            s = a_words[npaired] + b_words[npaired];
            p = int'(s % 32'd5);
            exp_mem[p][exp_tail[p]] = {1'b1, tbl_leaf[p], tbl_port[p], exp_seq[p], s};
            exp_seq[p] = exp_seq[p] + 1'b1;             // wraps at 128
            exp_tail[p]++;
            npaired++;
        end
    endtask

    task automatic check_dout();
        leaf_pkg::packet_t want;
        int                p;
        if (dout[leaf_pkg::pkt_vld_bit]) begin
            rx_count++;
            owed++;
            p = int'(dout[leaf_pkg::pkt_addr_lsb-1:0] % 32'd5);
            if (rx_count > credits + credit_pulses) begin
                report_error($sformatf("packet %0d sent without an outgoing credit", rx_count));
            end
            if (exp_head[p] == exp_tail[p]) begin
                report_error($sformatf("unexpected packet %h for output %0d", dout, p));
            end else begin
                want = exp_mem[p][exp_head[p]];
                exp_head[p]++;
                checks++;
                if (dout[47:39] != want[47:39]) begin
                    report_mismatch("routing", 64'(want[47:39]), 64'(dout[47:39]));
                end
                if (dout[38:32] != want[38:32]) begin
                    report_mismatch("ordering", 64'(want[38:32]), 64'(dout[38:32]));
                end
                if (dout[31:0] != want[31:0]) begin
                    report_mismatch("payload", 64'(want[31:0]), 64'(dout[31:0]));
                end
            end
        end else if (dout != '0) begin
            report_error($sformatf("dout is %h on an idle cycle", dout));
        end
    endtask

    // network side receiver, gives back one credit per packet taken
    task automatic return_credit();
        credit_in = 1'b0;
        if (hold) begin
            hold_cycles++;
            if (hold_cycles == hold_len) begin
                checks++;
                if (rx_count != credits + credit_pulses) begin
                    report_mismatch("outgoing credits", 64'(credits + credit_pulses),
                                    64'(rx_count));
                end
                hold = 1'b0;
            end
        end else if (owed > 0 && rand_bits(1) == 32'd1) begin
            credit_in = 1'b1;
            owed--;
            credit_pulses++;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        for (int i = 0; i < leaf_pkg::num_in; i++) begin
            cred[i] += pend[i];
            if (cred[i] > in_depth) begin
                report_error($sformatf("credit_out on input %0d with no word sent", i));
            end
            pend[i]      = int'(credit_out[i]);         // pop lands at the next edge
            co_total[i] += int'(credit_out[i]);
        end
        check_dout();
        return_credit();
    endtask

    function automatic bit all_received();
        bit r;
        r = (npaired == n_pairs);
        for (int p = 0; p < leaf_pkg::num_out; p++) begin
            if (exp_head[p] != exp_tail[p]) r = 1'b0;
        end
        return r;
    endfunction

    // ==========================================================================
    // stimulus
    // ==========================================================================
    initial begin : main_seq
        int                 pick;
        int                 drops;
        leaf_pkg::payload_t w;
        clk = 1'b0;
        rst_n = 1'b0;
        din = '0;
        credit_in = 1'b0;
        lfsr = 32'h62c0_34e6;
        errors = 0;
        checks = 0;
        npaired = 0;
        rx_count = 0;
        owed = 0;
        credit_pulses = 0;
        hold = 1'b0;
        hold_done = 1'b0;
        hold_cycles = 0;
        drops = 0;
        for (int i = 0; i < leaf_pkg::num_in; i++) begin
            cred[i] = in_depth;
            pend[i] = 0;
            co_total[i] = 0;
            sent[i] = 0;
        end
        for (int p = 0; p < leaf_pkg::num_out; p++) begin
            exp_seq[p] = '0;
            exp_head[p] = 0;
            exp_tail[p] = 0;
        end

        repeat (10) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        checks++;
        if (dout != '0) report_mismatch("reset dout", 64'd0, 64'(dout));
        if (credit_out != '0) report_mismatch("reset credit_out", 64'd0, 64'(credit_out));

        for (int o = 0; o < leaf_pkg::num_out; o++) begin
            tbl_leaf[o] = leaf_pkg::leaf_t'(rand_bits(5));
            tbl_port[o] = leaf_pkg::port_t'(rand_bits(4));
            din = make_packet(leaf_addr, leaf_pkg::cfg_port,
                              {20'd0, tbl_port[o], tbl_leaf[o], leaf_pkg::out_sel_t'(o)});
            next_cycle();
        end

        while (sent[0] < n_pairs || sent[1] < n_pairs || drops < n_drop) begin
            if (!hold_done && sent[0] >= hold_at) begin
                hold = 1'b1;
                hold_done = 1'b1;
                hold_cycles = 0;
            end
            din = '0;
            pick = int'(rand_bits(2));
            if (pick < leaf_pkg::num_in) begin
                if (sent[pick] < n_pairs && cred[pick] > 0) begin
                    w = rand_bits(32);
                    din = make_packet(leaf_addr,
                                      leaf_pkg::port_t'(int'(leaf_pkg::in_port_base) + pick), w);
                    if (pick == 0) a_words[sent[0]] = w;
                    else b_words[sent[1]] = w;
                    sent[pick]++;
                    cred[pick]--;
                    pair_words();
                end
            end else if (pick == 2 && drops < n_drop) begin
                din = drop_packet();
                drops++;
            end
            next_cycle();
        end
        din = '0;

        while (!all_received()) next_cycle();
        repeat (20) next_cycle();                       // nothing extra may show up

        for (int i = 0; i < leaf_pkg::num_in; i++) begin
            checks++;
            if (co_total[i] != n_pairs) begin
                report_mismatch($sformatf("incoming credits %0d", i), 64'(n_pairs),
                                64'(co_total[i]));
            end
        end
        if (rx_count != n_pairs) report_mismatch("packet count", 64'(n_pairs), 64'(rx_count));

        $display("packets %0d, checks %0d, errors %0d", rx_count, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (50 * total_words) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", 50 * total_words);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
leaf_pkg.sv
leaf_fifo.sv
leaf_decode.sv
leaf_kernel.sv
leaf_result.sv
leaf_i2o5.sv
tb_leaf_i2o5.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_leaf_i2o5 \
    -f vlog.f -o tb_leaf_i2o5 &&
./obj_dir/tb_leaf_i2o5 | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "leaf_i2o5 simulation passed" ||
{ echo "leaf_i2o5 simulation failed"; exit 1; }
